//--- test/snowball_memsys_tests.txt
// kind: 0 load, 1 store, 2 tlbw, 3 vmem, 4 force-miss load, f end of list
// kind addr data exp_val exp_bus_addr bus_xfers fault
0 00000104 00000000 5a5aa4a1 00000104 2 0
0 00000105 00000000 5a5aa4a0 00000000 0 0
0 00000104 00000000 5a5aa4a1 00000000 0 0
1 00000105 11112222 00000000 00000105 1 0
0 00000105 00000000 11112222 00000000 0 0
1 00000230 cafe0001 00000000 00000230 1 0
0 00000230 00000000 cafe0001 00000230 2 0
4 00000105 00000000 11112222 00000104 2 0
0 c0000010 00000000 3fffffef c0000010 2 0
1 c0000020 0badf00d 00000000 c0000020 1 0
2 00001200 00400007 00000000 3f001200 1 0
3 00000000 00000001 00000000 00000000 0 0
0 00071234 00000000 5a1ab791 00401234 2 0
0 00081235 00000000 00000000 00000000 0 1
1 00071236 5555aaaa 00000000 00401236 1 0
3 00000000 00000000 00000000 00000000 0 0
0 00401236 00000000 5555aaaa 00401236 2 0
0 00401234 00000000 5a1ab791 00000000 0 0
f 00000000 00000000 00000000 00000000 0 0

//--- snowball_memsys.f
common/snowball_pkg.sv
common/snowball_bus_pkg.sv
cache/cache_ctrl.sv
cache/tlb.sv
src/bus_arbiter.sv
src/snowball_memsys.sv
test/snowball_memsys_checker.sv
test/snowball_memsys_monitor.sv
test/snowball_memsys_tb.sv

//--- Makefile
SIM      = verilator
TOP      = snowball_memsys_tb
FILELIST = snowball_memsys.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS    := $(shell grep -v '^+' $(FILELIST))

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: all run clean

//--- test/snowball_memsys_tb.sv
`timescale 1ns/1ps

module snowball_memsys_tb;

  logic        CPU_CLK, RST_CPU;
  logic [31:0] cache_precycle_addr, cache_datao;
  logic        cache_precycle_we, cache_precycle_enable, cache_precycle_force_miss;
  logic        we_tlb, vmem_act;
  logic        mem_ack, dma_read_ack, dma_wrte_ack;
  logic [31:0] mem_datafrommem, dma_data_read;
  logic [31:0] cache_datai, mem_addr, mem_dataintomem;
  logic        cache_busy, mmu_fault, mem_we, mem_do_act, dma_read, dma_wrte;

  logic        test_start, test_end, summary;
  logic [31:0] t_kind, t_data, t_exp_val, t_exp_addr, t_exp_xfer, t_exp_fault;
  logic [31:0] vec [0:7*64-1];   // seven columns per test
  logic [31:0] mem_model [logic [31:0]];
  int          n_tests, err_count;

  snowball_memsys #(.idx_w(8)) dut0 (.*);

  snowball_memsys_monitor mon0 (.*);

  always #5 CPU_CLK = ~CPU_CLK;

  function automatic logic [31:0] read_word(input logic [31:0] a);
    if (mem_model.exists(a))
      return mem_model[a];
    return a ^ 32'h5a5a_a5a5;      // unwritten fill
  endfunction

  // ----------------------------
  // memory and dma responder
  // ----------------------------
  initial
  begin : responder
    int wait_left;
    wait_left = -1;
    forever
    begin
      @(posedge CPU_CLK);
      #1;
      mem_ack      = 1'b0;
      dma_read_ack = 1'b0;
      dma_wrte_ack = 1'b0;
      if (!RST_CPU && (mem_do_act || dma_read || dma_wrte))
      begin
        if (wait_left < 0)
          wait_left = int'($urandom % 4);
        if (wait_left == 0)
        begin
          if (mem_do_act && mem_we)
            mem_model[mem_addr] = mem_dataintomem;
          mem_datafrommem = read_word(mem_addr);
          dma_data_read   = ~mem_addr;
          mem_ack         = mem_do_act;
          dma_read_ack    = dma_read;
          dma_wrte_ack    = dma_wrte;
        end
        wait_left--;
      end
    end
  end

  task automatic run_test(input int t);
    logic [31:0] kind;
    kind        = vec[t*7];
    t_kind      = kind;
    t_data      = vec[t*7+2];
    t_exp_val   = vec[t*7+3];
    t_exp_addr  = vec[t*7+4];
    t_exp_xfer  = vec[t*7+5];
    t_exp_fault = vec[t*7+6];
    cache_precycle_addr = vec[t*7+1];
    cache_datao         = vec[t*7+2];
    test_start          = 1'b1;
    case (kind)
      32'h0, 32'h4:
      begin
        cache_precycle_enable     = 1'b1;
        cache_precycle_force_miss = (kind == 32'h4);
      end
      32'h1:
      begin
        cache_precycle_enable = 1'b1;
        cache_precycle_we     = 1'b1;
      end
      32'h2: we_tlb = 1'b1;
      default: vmem_act = vec[t*7+2][0];
    endcase
    @(posedge CPU_CLK);
    #1;
    test_start                = 1'b0;
    cache_precycle_enable     = 1'b0;
    cache_precycle_we         = 1'b0;
    cache_precycle_force_miss = 1'b0;
    we_tlb                    = 1'b0;
    @(posedge CPU_CLK);             // lookup cycle done
    #1;
    while (cache_busy)
    begin
      @(posedge CPU_CLK);
      #1;
    end
    @(posedge CPU_CLK);             // let a fault cycle pass
    #1;
    test_end = 1'b1;
    @(posedge CPU_CLK);
    #1;
    test_end = 1'b0;
  endtask

  initial
  begin : watchdog
    @(negedge RST_CPU);
    repeat (n_tests * 40 + 32) @(posedge CPU_CLK);
    $display("TIMEOUT: tests did not finish within %0d cycles", n_tests * 40);
    $display("Done: errors found");
    $finish;
  end

  initial
  begin : main
    CPU_CLK = 1'b0;
    RST_CPU = 1'b1;
    cache_precycle_addr = '0;
    cache_datao = '0;
    cache_precycle_we = 1'b0;
    cache_precycle_enable = 1'b0;
    cache_precycle_force_miss = 1'b0;
    we_tlb = 1'b0;
    vmem_act = 1'b0;
    mem_ack = 1'b0;
    dma_read_ack = 1'b0;
    dma_wrte_ack = 1'b0;
    mem_datafrommem = '0;
    dma_data_read = '0;
    test_start = 1'b0;
    test_end = 1'b0;
    summary = 1'b0;
    n_tests = 0;
    void'($urandom(32'hf321_4769));
    $readmemh("test/snowball_memsys_tests.txt", vec);
    while (n_tests < 64 && vec[n_tests*7] !== 32'hf)   // kind f ends the list
      n_tests++;
    repeat (16) @(posedge CPU_CLK);
    #1;
    RST_CPU = 1'b0;
    @(posedge CPU_CLK);
    #1;
    for (int t = 0; t < n_tests; t++)
      run_test(t);
    summary = 1'b1;
    @(posedge CPU_CLK);
    #1;
    if (err_count == 0 && dut0.chk0.fail_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- test/snowball_memsys_monitor.sv
`timescale 1ns/1ps

module snowball_memsys_monitor (
  input  logic        CPU_CLK,
  input  logic        test_start,
  input  logic        test_end,
  input  logic        summary,
  input  logic [31:0] t_kind,
  input  logic [31:0] t_data,
  input  logic [31:0] t_exp_val,
  input  logic [31:0] t_exp_addr,
  input  logic [31:0] t_exp_xfer,
  input  logic [31:0] t_exp_fault,
  input  logic [31:0] cache_datai,
  input  logic        cache_busy,
  input  logic        mmu_fault,
  input  logic [31:0] mem_addr,
  input  logic        mem_we,
  input  logic        mem_do_act,
  input  logic [31:0] mem_dataintomem,
  input  logic        dma_read,
  input  logic        dma_wrte,
  input  logic        mem_ack,
  input  logic        dma_read_ack,
  input  logic        dma_wrte_ack,
  output int          err_count
);

  int          test_num, xfers, faults, bad;
  logic        busy_seen, first_we, first_dma;
  logic [31:0] first_addr, first_wdata;
  logic        ack;

  assign ack = (mem_do_act && mem_ack) || (dma_read && dma_read_ack) ||
               (dma_wrte && dma_wrte_ack);

  initial
  begin
    err_count = 0;
    test_num  = 0;
  end

  task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("CHECK FAILED at %0t: test %0d %s got %h expected %h",
             $time, test_num, what, got, exp);
    bad++;
  endtask

  // ----------------------------
  // per-test comparison
  // ----------------------------
  task automatic check_test();
    bad = 0;
    if (xfers != int'(t_exp_xfer))
      mismatch("bus transfers", xfers, t_exp_xfer);
    if (faults != int'(t_exp_fault))
      mismatch("mmu_fault cycles", faults, t_exp_fault);
    if (t_exp_xfer == 0 && t_kind == 32'h0 && busy_seen)
      mismatch("cache_busy on a hit", 32'd1, 32'd0);
    if (xfers > 0)
    begin
      if (first_addr !== t_exp_addr)
        mismatch("bus address", first_addr, t_exp_addr);
      if (first_dma !== (t_exp_addr[31:30] == 2'b11))
        mismatch("dma port use", first_dma, t_exp_addr[31:30] == 2'b11);
    end
    if (t_kind == 32'h1 || t_kind == 32'h2)   // store or tlb mirror
    begin
      if (first_wdata !== t_data)
        mismatch("bus write data", first_wdata, t_data);
      if (first_we !== 1'b1)
        mismatch("bus write enable", first_we, 32'd1);
    end
    if ((t_kind == 32'h0 || t_kind == 32'h4) && t_exp_fault == 0)
    begin
      if (cache_datai !== t_exp_val)
        mismatch("load data", cache_datai, t_exp_val);
      if (xfers > 0 && first_we !== 1'b0)
        mismatch("fill write enable", first_we, 32'd0);
    end
    if (bad == 0)
      $display("test %0d kind %0h ok", test_num, t_kind);
    else
      $display("test %0d kind %0h FAILED", test_num, t_kind);
    err_count += bad;
    test_num++;
  endtask

  always @(posedge CPU_CLK)
  begin
    if (test_start)
    begin
      xfers     = 0;
      faults    = 0;
      busy_seen = 1'b0;
    end
    else
    begin
      if (mmu_fault)
        faults++;
      if (cache_busy)
        busy_seen = 1'b1;
      if (ack)
      begin
        if (xfers == 0)                       // keep the first transfer
        begin
          first_addr  = mem_addr;
          first_wdata = mem_dataintomem;
          first_we    = mem_we || dma_wrte;
          first_dma   = dma_read || dma_wrte;
        end
        xfers++;
      end
      if (test_end)
        check_test();
    end
    if (summary)
      $display("tests run %0d, errors %0d", test_num, err_count);
  end

endmodule

//--- test/snowball_memsys_checker.sv
`timescale 1ns/1ps

module snowball_memsys_checker (
  input logic CPU_CLK,
  input logic RST_CPU,
  input logic mem_do_act,
  input logic mem_ack,
  input logic dma_read,
  input logic dma_wrte,
  input logic mmu_fault
);

  int fail_count = 0;

  // one port active at a time
  port_exclusive: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    !(mem_do_act && (dma_read || dma_wrte)))
  else
  begin
    fail_count++;
    $error("memory and dma strobes overlap");
  end

  mem_held: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    (mem_do_act && !mem_ack) |=> mem_do_act)
  else
  begin
    fail_count++;
    $error("mem_do_act dropped before mem_ack");
  end

  fault_pulse: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    mmu_fault |=> !mmu_fault)
  else
  begin
    fail_count++;
    $error("mmu_fault longer than one cycle");
  end

endmodule

bind snowball_memsys snowball_memsys_checker chk0 (
  .CPU_CLK    (CPU_CLK),
  .RST_CPU    (RST_CPU),
  .mem_do_act (mem_do_act),
  .mem_ack    (mem_ack),
  .dma_read   (dma_read),
  .dma_wrte   (dma_wrte),
  .mmu_fault  (mmu_fault)
);

//--- src/snowball_memsys.sv
`timescale 1ns/1ps

module snowball_memsys #(
  parameter int idx_w = 8
) (
  input  logic                CPU_CLK,
  input  logic                RST_CPU,
  input  snowball_pkg::addr_t cache_precycle_addr,
  input  logic [31:0]         cache_datao,
  input  logic                cache_precycle_we,
  input  logic                cache_precycle_enable,
  input  logic                cache_precycle_force_miss,
  input  logic                we_tlb,
  input  logic                vmem_act,
  input  logic                mem_ack,
  input  logic [31:0]         mem_datafrommem,
  input  logic                dma_read_ack,
  input  logic                dma_wrte_ack,
  input  logic [31:0]         dma_data_read,
  output logic [31:0]         cache_datai,
  output logic                cache_busy,
  output logic                mmu_fault,
  output snowball_pkg::addr_t mem_addr,
  output logic                mem_we,
  output logic                mem_do_act,
  output logic [31:0]         mem_dataintomem,
  output logic                dma_read,
  output logic                dma_wrte
);
  import snowball_pkg::*;

  // tlb to cache
  logic [15:0] phys_tag;
  logic        tlb_fault, tlb_busy;

  // ----------------------------
  // master side of the arbiter
  // ----------------------------
  logic        cache_bus_req, cache_bus_we, cache_bus_done;
  addr_t       cache_bus_addr;
  logic [31:0] cache_bus_wdata;
  logic        tlb_bus_req, tlb_bus_done;
  addr_t       tlb_bus_addr;
  bus_word_u   tlb_bus_wdata;
  logic [31:0] bus_rdata;

  cache_ctrl #(
    .idx_w(idx_w)
  ) u_cache (
    .CPU_CLK                   (CPU_CLK),
    .RST_CPU                   (RST_CPU),
    .cache_precycle_addr       (cache_precycle_addr),
    .cache_datao               (cache_datao),
    .cache_precycle_we         (cache_precycle_we),
    .cache_precycle_enable     (cache_precycle_enable),
    .cache_precycle_force_miss (cache_precycle_force_miss),
    .phys_tag                  (phys_tag),
    .tlb_fault                 (tlb_fault),
    .tlb_busy                  (tlb_busy),
    .vmem_act                  (vmem_act),
    .cache_bus_done            (cache_bus_done),
    .bus_rdata                 (bus_rdata),
    .cache_datai               (cache_datai),
    .cache_busy                (cache_busy),
    .mmu_fault                 (mmu_fault),
    .cache_bus_req             (cache_bus_req),
    .cache_bus_we              (cache_bus_we),
    .cache_bus_addr            (cache_bus_addr),
    .cache_bus_wdata           (cache_bus_wdata)
  );

  tlb u_tlb (
    .CPU_CLK               (CPU_CLK),
    .RST_CPU               (RST_CPU),
    .cache_precycle_addr   (cache_precycle_addr),
    .cache_datao           (cache_datao),
    .cache_precycle_enable (cache_precycle_enable),
    .we_tlb                (we_tlb),
    .vmem_act              (vmem_act),
    .tlb_bus_done          (tlb_bus_done),
    .phys_tag              (phys_tag),
    .tlb_fault             (tlb_fault),
    .tlb_busy              (tlb_busy),
    .tlb_bus_req           (tlb_bus_req),
    .tlb_bus_addr          (tlb_bus_addr),
    .tlb_bus_wdata         (tlb_bus_wdata)
  );

  bus_arbiter u_arb (
    .CPU_CLK         (CPU_CLK),
    .RST_CPU         (RST_CPU),
    .cache_bus_req   (cache_bus_req),
    .cache_bus_we    (cache_bus_we),
    .cache_bus_addr  (cache_bus_addr),
    .cache_bus_wdata (cache_bus_wdata),
    .tlb_bus_req     (tlb_bus_req),
    .tlb_bus_addr    (tlb_bus_addr),
    .tlb_bus_wdata   (tlb_bus_wdata),
    .mem_ack         (mem_ack),
    .mem_datafrommem (mem_datafrommem),
    .dma_read_ack    (dma_read_ack),
    .dma_wrte_ack    (dma_wrte_ack),
    .dma_data_read   (dma_data_read),
    .cache_bus_done  (cache_bus_done),
    .tlb_bus_done    (tlb_bus_done),
    .bus_rdata       (bus_rdata),
    .mem_addr        (mem_addr),
    .mem_we          (mem_we),
    .mem_do_act      (mem_do_act),
    .mem_dataintomem (mem_dataintomem),
    .dma_read        (dma_read),
    .dma_wrte        (dma_wrte)
  );

endmodule

//--- src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                    CPU_CLK,
  input  logic                    RST_CPU,
  input  logic                    cache_bus_req,
  input  logic                    cache_bus_we,
  input  snowball_pkg::addr_t     cache_bus_addr,
  input  logic [31:0]             cache_bus_wdata,
  input  logic                    tlb_bus_req,
  input  snowball_pkg::addr_t     tlb_bus_addr,
  input  snowball_pkg::bus_word_u tlb_bus_wdata,
  input  logic                    mem_ack,
  input  logic [31:0]             mem_datafrommem,
  input  logic                    dma_read_ack,
  input  logic                    dma_wrte_ack,
  input  logic [31:0]             dma_data_read,
  output logic                    cache_bus_done,
  output logic                    tlb_bus_done,
  output logic [31:0]             bus_rdata,
  output snowball_pkg::addr_t     mem_addr,
  output logic                    mem_we,
  output logic                    mem_do_act,
  output logic [31:0]             mem_dataintomem,
  output logic                    dma_read,
  output logic                    dma_wrte
);
  import snowball_pkg::*;
  import snowball_bus_pkg::*;

  logic        busy_q, gnt_tlb, ack;
  addr_t       req_addr;
  logic        req_we, req_dma;
  logic [31:0] req_wdata;

  assign ack = (mem_do_act && mem_ack) || (dma_read && dma_read_ack) ||
               (dma_wrte && dma_wrte_ack);
  assign cache_bus_done = ack && !gnt_tlb;
  assign tlb_bus_done   = ack && gnt_tlb;
  assign bus_rdata      = dma_read ? dma_data_read : mem_datafrommem;

  // tlb mirror wins a tie
  always_comb
  begin
    if (tlb_bus_req)
    begin
      req_addr  = tlb_bus_addr;
      req_we    = 1'b1;                // mirrors only ever write
      req_wdata = tlb_bus_wdata.data;
    end
    else
    begin
      req_addr  = cache_bus_addr;
      req_we    = cache_bus_we;
      req_wdata = cache_bus_wdata;
    end
  end

  assign req_dma = is_dma(req_addr);

  // ----------------------------
  // grant and port strobes
  // ----------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      busy_q     <= 1'b0;
      gnt_tlb    <= 1'b0;
      mem_do_act <= 1'b0;
      mem_we     <= 1'b0;
      dma_read   <= 1'b0;
      dma_wrte   <= 1'b0;
    end
    else if (!busy_q)
    begin
      if (tlb_bus_req || cache_bus_req)
      begin
        busy_q     <= 1'b1;
        gnt_tlb    <= tlb_bus_req;
        mem_do_act <= !req_dma;
        mem_we     <= !req_dma && req_we;
        dma_read   <= req_dma && !req_we;
        dma_wrte   <= req_dma && req_we;
      end
    end
    else if (ack)
    begin
      busy_q     <= 1'b0;              // back to idle, master sees done
      mem_do_act <= 1'b0;
      mem_we     <= 1'b0;
      dma_read   <= 1'b0;
      dma_wrte   <= 1'b0;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!busy_q)
    begin
      mem_addr        <= req_addr;
      mem_dataintomem <= req_wdata;    // dma writes use it too
    end
  end

endmodule

//--- cache/tlb.sv
`timescale 1ns/1ps

module tlb (
  input  logic                    CPU_CLK,
  input  logic                    RST_CPU,
  input  snowball_pkg::addr_t     cache_precycle_addr,
  input  logic [31:0]             cache_datao,
  input  logic                    cache_precycle_enable,
  input  logic                    we_tlb,
  input  logic                    vmem_act,
  input  logic                    tlb_bus_done,
  output logic [15:0]             phys_tag,
  output logic                    tlb_fault,
  output logic                    tlb_busy,
  output logic                    tlb_bus_req,
  output snowball_pkg::addr_t     tlb_bus_addr,
  output snowball_pkg::bus_word_u tlb_bus_wdata
);
  import snowball_pkg::*;
  import snowball_bus_pkg::*;

  tlb_entry_t           ent_mem [2**tlb_idx_w];
  tlb_entry_t           ent_q;
  logic [15:0]          vreq_q;  // virtual tag of the request
  logic                 wr_q;
  logic [tlb_idx_w-1:0] wr_idx;
  bus_word_u            wr_word;

  // lookup answers in the cycle after the request
  assign phys_tag  = ent_q.ptag;
  assign tlb_fault = vmem_act && (ent_q.vtag != vreq_q);
  assign tlb_busy  = wr_q || tlb_bus_req;

  always_ff @(posedge CPU_CLK)
  begin
    if (cache_precycle_enable)
    begin
      ent_q  <= ent_mem[cache_precycle_addr[8 +: tlb_idx_w]];
      vreq_q <= cache_precycle_addr[31:16];
    end
    if (we_tlb)
    begin
      wr_idx       <= cache_precycle_addr[8 +: tlb_idx_w];
      wr_word.data <= cache_datao;
    end
    if (wr_q)
    begin
      ent_mem[wr_idx] <= wr_word.entry;
      tlb_bus_addr    <= shadow_addr(wr_idx);  // mirror target
      tlb_bus_wdata   <= wr_word;
    end
  end

  // ----------------------------
  // mirror request
  // ----------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      wr_q        <= 1'b0;
      tlb_bus_req <= 1'b0;
    end
    else
    begin
      wr_q <= we_tlb;
      if (wr_q)
        tlb_bus_req <= 1'b1;
      else if (tlb_bus_done)
        tlb_bus_req <= 1'b0;           // shadow write landed
    end
  end

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int idx_w = 8
) (
  input  logic                CPU_CLK,
  input  logic                RST_CPU,
  input  snowball_pkg::addr_t cache_precycle_addr,
  input  logic [31:0]         cache_datao,
  input  logic                cache_precycle_we,
  input  logic                cache_precycle_enable,
  input  logic                cache_precycle_force_miss,
  input  logic [15:0]         phys_tag,
  input  logic                tlb_fault,
  input  logic                tlb_busy,
  input  logic                vmem_act,
  input  logic                cache_bus_done,
  input  logic [31:0]         bus_rdata,
  output logic [31:0]         cache_datai,
  output logic                cache_busy,
  output logic                mmu_fault,
  output logic                cache_bus_req,
  output logic                cache_bus_we,
  output snowball_pkg::addr_t cache_bus_addr,
  output logic [31:0]         cache_bus_wdata
);
  import snowball_pkg::*;

  localparam int off_w  = $clog2(line_words);
  localparam int lines  = (2 ** idx_w) / line_words;
  localparam int ctag_w = tag_w + 8 - idx_w;  // addr 31 down to idx_w

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_fill0 = 2'd1;
  localparam logic [1:0] st_fill1 = 2'd2;
  localparam logic [1:0] st_store = 2'd3;

  logic [31:0]       data_mem [2**idx_w];
  logic [ctag_w-1:0] tag_mem [lines];
  logic [lines-1:0]  vld_mem;

  logic [1:0]        state;
  logic              busy_q, look_vld, rp_vld;
  logic              look_we, look_fm, rp_we, rp_fm, st_hit, ld_off;
  addr_t             look_addr, rp_addr, rd_addr, paddr;
  logic [31:0]       look_wdata, rp_wdata, word0_q, data_q, arr_wdata;
  logic [ctag_w-1:0] tag_q;
  logic              vld_q;
  logic              accept, fin, rp_issue, hit, fault, to_bus, arr_we, tag_we;

  assign cache_busy = busy_q || tlb_busy;
  assign accept     = cache_precycle_enable && !cache_busy;
  assign fin        = cache_bus_done && (state == st_fill1 || state == st_store);
  assign rp_issue   = rp_vld && fin;       // replay right as the bus work ends
  assign rd_addr    = rp_issue ? rp_addr : cache_precycle_addr;

  // ----------------------------
  // lookup stage
  // ----------------------------
  assign paddr  = vmem_act ? {phys_tag, look_addr[15:0]} : look_addr;
  assign hit    = vld_q && (tag_q == paddr[31:idx_w]) && !look_fm;
  assign fault  = look_vld && tlb_fault;
  assign to_bus = look_vld && !fault && (look_we || !hit);

  // one write port, fed by the bus side
  assign arr_we = cache_bus_done &&
                  (state == st_fill0 || state == st_fill1 || (state == st_store && st_hit));
  assign tag_we    = cache_bus_done && state == st_fill1;
  assign arr_wdata = (state == st_store) ? cache_bus_wdata : bus_rdata;

  always_ff @(posedge CPU_CLK)
  begin
    if (arr_we)
      data_mem[cache_bus_addr[idx_w-1:0]] <= arr_wdata;
    if (tag_we)
      tag_mem[cache_bus_addr[idx_w-1:off_w]] <= cache_bus_addr[31:idx_w];
    // same-edge write wins over the old array word
    if (arr_we && cache_bus_addr[idx_w-1:0] == rd_addr[idx_w-1:0])
      data_q <= arr_wdata;
    else
      data_q <= data_mem[rd_addr[idx_w-1:0]];
    if (tag_we && cache_bus_addr[idx_w-1:off_w] == rd_addr[idx_w-1:off_w])
    begin
      tag_q <= cache_bus_addr[31:idx_w];
      vld_q <= 1'b1;
    end
    else
    begin
      tag_q <= tag_mem[rd_addr[idx_w-1:off_w]];
      vld_q <= vld_mem[rd_addr[idx_w-1:off_w]];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      vld_mem       <= '0;
      state         <= st_idle;
      busy_q        <= 1'b0;
      look_vld      <= 1'b0;
      rp_vld        <= 1'b0;
      mmu_fault     <= 1'b0;
      cache_bus_req <= 1'b0;
    end
    else
    begin
      look_vld  <= (accept && !to_bus) || rp_issue;
      mmu_fault <= fault;              // one cycle, after the lookup
      if (tag_we)
        vld_mem[cache_bus_addr[idx_w-1:off_w]] <= 1'b1;
      if (accept && to_bus)
        rp_vld <= 1'b1;                // parked behind the miss
      else if (rp_issue)
        rp_vld <= 1'b0;
      case (state)
        st_idle:
          if (to_bus)
          begin
            state         <= look_we ? st_store : st_fill0;
            busy_q        <= 1'b1;
            cache_bus_req <= 1'b1;
          end
        st_fill0:
          if (cache_bus_done)
            state <= st_fill1;         // req stays up for word 1
        default:
          if (cache_bus_done)
          begin
            state         <= st_idle;
            busy_q        <= 1'b0;
            cache_bus_req <= 1'b0;
          end
      endcase
    end
  end

  // ----------------------------
  // request and bus payload
  // ----------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      rp_addr  <= cache_precycle_addr;
      rp_we    <= cache_precycle_we;
      rp_fm    <= cache_precycle_force_miss;
      rp_wdata <= cache_datao;
    end
    if (rp_issue)
    begin
      look_addr  <= rp_addr;
      look_we    <= rp_we;
      look_fm    <= rp_fm;
      look_wdata <= rp_wdata;
    end
    else if (accept)
    begin
      look_addr  <= cache_precycle_addr;
      look_we    <= cache_precycle_we;
      look_fm    <= cache_precycle_force_miss;
      look_wdata <= cache_datao;
    end

    if (look_vld && !fault && !look_we && hit)
      cache_datai <= data_q;           // load hit
    if (state == st_idle && to_bus)
    begin
      cache_bus_we    <= look_we;
      cache_bus_addr  <= look_we ? paddr : {paddr[31:off_w], {off_w{1'b0}}};
      cache_bus_wdata <= look_wdata;
      st_hit          <= hit;
      ld_off          <= paddr[0];
    end
    if (cache_bus_done && state == st_fill0)
    begin
      word0_q        <= bus_rdata;
      cache_bus_addr <= cache_bus_addr + 32'd1;  // second word of the line
    end
    if (cache_bus_done && state == st_fill1)
      cache_datai <= ld_off ? bus_rdata : word0_q;
  end

endmodule

//--- common/snowball_bus_pkg.sv
package snowball_bus_pkg;

  typedef logic [1:0] region_t;  // top two address bits

  localparam region_t region_dma = 2'b11;

  // shadow copy of the tlb lives in ordinary memory
  localparam logic [15:0] tlb_shadow_base = 16'h3f00;

  function automatic region_t region_of(snowball_pkg::addr_t addr);
    return addr[31:30];
  endfunction

  function automatic logic is_dma(snowball_pkg::addr_t addr);
    return region_of(addr) == region_dma;
  endfunction

  // base, then entry index, then a zero word offset
  function automatic snowball_pkg::addr_t shadow_addr(
    logic [snowball_pkg::tlb_idx_w-1:0] idx
  );
    return {tlb_shadow_base, idx, {(16 - snowball_pkg::tlb_idx_w){1'b0}}};
  endfunction

endpackage

//--- common/snowball_pkg.sv
package snowball_pkg;

  typedef logic [31:0] addr_t;  // word address, one unit per 32-bit word

  // ----------------------------
  // cache geometry
  // ----------------------------
  localparam int line_words = 2;  // words per line
  localparam int tag_w      = 24; // addr 31:8 at the default index width

  // ----------------------------
  // tlb geometry and entry layout
  // ----------------------------
  localparam int tlb_idx_w = 8;   // entry index taken from addr 15:8

  // ptag in the upper half of the loaded word, vtag in the lower half
  typedef struct packed {
    logic [15:0] ptag;
    logic [15:0] vtag;
  } tlb_entry_t;

  // one 32-bit word of the cpu write path
  // the tlb takes it as an entry, the bus moves it as plain data
  typedef union packed {
    logic [31:0] data;
    tlb_entry_t  entry;
  } bus_word_u;

endpackage
